// File: hw/decode_pkg.sv
// shared widths, opcode constants, enums and packet structs for the decode stage and its testbench
`default_nettype none

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011; // conv accelerator ops
    localparam logic [6:0] OPC_FENCE   = 7'b0001111;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    // funct7 patterns, F7_ANY matches anything in a casez
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra, srai
    localparam logic [6:0] F7_MULDIV = 7'b0000001;
    localparam logic [6:0] F7_CONV   = 7'b?000000; // bit 31 carries the accumulate enable
    localparam logic [6:0] F7_ANY    = 7'b???????;
    localparam logic [2:0] F3_ANY    = 3'b???;

    // conv ops select on funct3 under OPC_CUSTOM0
    localparam logic [2:0] F3_CONV_LD_W = 3'b000;
    localparam logic [2:0] F3_CONV_LD_X = 3'b001;
    localparam logic [2:0] F3_CONV_CLR  = 3'b010;
    localparam logic [2:0] F3_CONV_RUN  = 3'b011;

    localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [5:0] {
        UOP_NOP = 6'd0,
        UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU, UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
        UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI, UOP_ANDI, UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR, UOP_LUI, UOP_AUIPC, UOP_FENCE, UOP_ECALL, UOP_EBREAK,
        UOP_MUL, UOP_MULH, UOP_MULHSU, UOP_MULHU, UOP_DIV, UOP_DIVU, UOP_REM, UOP_REMU,
        UOP_CONV_LD_W, UOP_CONV_LD_X, UOP_CONV_CLR, UOP_CONV_RUN
    } uop_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0, // register file value
        FWD_EX   = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_J, IMM_U, IMM_SHAMT
    } imm_fmt_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_next;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_pkt_t;

    typedef struct packed {
        uop_e                  uop;
        imm_fmt_e              imm_fmt;
        logic [XLEN-1:0]       imm;
        logic                  use_pc_a;  // op_a is pc
        logic                  use_imm_b; // op_b is the immediate
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_wr;
        logic                  acc_en;
        logic                  illegal;
    } dec_info_t;

    typedef struct packed {
        logic                  valid;
        uop_e                  uop;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_wr;
        logic                  acc_en;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc_next;
        logic [2:0]            cmp; // {lt, ltu, eq}
        logic                  illegal;
    } ex_pkt_t;

    localparam ex_pkt_t EX_BUBBLE = '0; // uop is UOP_NOP

endpackage

`default_nettype wire

// File: hw/instr_decoder.sv
// combinational decoder, turns one instruction word into a micro-op, operand selects and immediate
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic [decode_pkg::XLEN-1:0] instr_i,
    output decode_pkg::dec_info_t            dec_o
);
    import decode_pkg::*;

    uop_e            uop;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;
    logic            use_pc_a;
    logic            use_imm_b;
    logic            rd_wr;
    logic            illegal;
    logic [6:0]      opcode;
    logic [16:0]     match_key; // {funct7, funct3, opcode}

    assign opcode    = instr_i[6:0];
    assign match_key = {instr_i[31:25], instr_i[14:12], opcode};

    // fixed system words first, then the field patterns, most specific first
    always_comb begin
        uop     = UOP_NOP;
        illegal = 1'b0;
        if (instr_i == INSTR_ECALL) begin
            uop = UOP_ECALL;
        end else if (instr_i == INSTR_EBREAK) begin
            uop = UOP_EBREAK;
        end else begin
            casez (match_key)
                {F7_BASE,   3'b000, OPC_OP}:      uop = UOP_ADD;
                {F7_ALT,    3'b000, OPC_OP}:      uop = UOP_SUB;
                {F7_BASE,   3'b001, OPC_OP}:      uop = UOP_SLL;
                {F7_BASE,   3'b010, OPC_OP}:      uop = UOP_SLT;
                {F7_BASE,   3'b011, OPC_OP}:      uop = UOP_SLTU;
                {F7_BASE,   3'b100, OPC_OP}:      uop = UOP_XOR;
                {F7_BASE,   3'b101, OPC_OP}:      uop = UOP_SRL;
                {F7_ALT,    3'b101, OPC_OP}:      uop = UOP_SRA;
                {F7_BASE,   3'b110, OPC_OP}:      uop = UOP_OR;
                {F7_BASE,   3'b111, OPC_OP}:      uop = UOP_AND;
                {F7_MULDIV, 3'b000, OPC_OP}:      uop = UOP_MUL;
                {F7_MULDIV, 3'b001, OPC_OP}:      uop = UOP_MULH;
                {F7_MULDIV, 3'b010, OPC_OP}:      uop = UOP_MULHSU;
                {F7_MULDIV, 3'b011, OPC_OP}:      uop = UOP_MULHU;
                {F7_MULDIV, 3'b100, OPC_OP}:      uop = UOP_DIV;
                {F7_MULDIV, 3'b101, OPC_OP}:      uop = UOP_DIVU;
                {F7_MULDIV, 3'b110, OPC_OP}:      uop = UOP_REM;
                {F7_MULDIV, 3'b111, OPC_OP}:      uop = UOP_REMU;
                {F7_BASE,   3'b001, OPC_OPIMM}:   uop = UOP_SLLI;
                {F7_BASE,   3'b101, OPC_OPIMM}:   uop = UOP_SRLI;
                {F7_ALT,    3'b101, OPC_OPIMM}:   uop = UOP_SRAI;
                {F7_ANY,    3'b000, OPC_OPIMM}:   uop = UOP_ADDI;
                {F7_ANY,    3'b010, OPC_OPIMM}:   uop = UOP_SLTI;
                {F7_ANY,    3'b011, OPC_OPIMM}:   uop = UOP_SLTIU;
                {F7_ANY,    3'b100, OPC_OPIMM}:   uop = UOP_XORI;
                {F7_ANY,    3'b110, OPC_OPIMM}:   uop = UOP_ORI;
                {F7_ANY,    3'b111, OPC_OPIMM}:   uop = UOP_ANDI;
                {F7_ANY,    3'b000, OPC_LOAD}:    uop = UOP_LB;
                {F7_ANY,    3'b001, OPC_LOAD}:    uop = UOP_LH;
                {F7_ANY,    3'b010, OPC_LOAD}:    uop = UOP_LW;
                {F7_ANY,    3'b100, OPC_LOAD}:    uop = UOP_LBU;
                {F7_ANY,    3'b101, OPC_LOAD}:    uop = UOP_LHU;
                {F7_ANY,    3'b000, OPC_STORE}:   uop = UOP_SB;
                {F7_ANY,    3'b001, OPC_STORE}:   uop = UOP_SH;
                {F7_ANY,    3'b010, OPC_STORE}:   uop = UOP_SW;
                {F7_ANY,    3'b000, OPC_BRANCH}:  uop = UOP_BEQ;
                {F7_ANY,    3'b001, OPC_BRANCH}:  uop = UOP_BNE;
                {F7_ANY,    3'b100, OPC_BRANCH}:  uop = UOP_BLT;
                {F7_ANY,    3'b101, OPC_BRANCH}:  uop = UOP_BGE;
                {F7_ANY,    3'b110, OPC_BRANCH}:  uop = UOP_BLTU;
                {F7_ANY,    3'b111, OPC_BRANCH}:  uop = UOP_BGEU;
                {F7_ANY,    3'b000, OPC_JALR}:    uop = UOP_JALR;
                {F7_ANY,    F3_ANY, OPC_JAL}:     uop = UOP_JAL;
                {F7_ANY,    F3_ANY, OPC_LUI}:     uop = UOP_LUI;
                {F7_ANY,    F3_ANY, OPC_AUIPC}:   uop = UOP_AUIPC;
                {F7_ANY,    3'b000, OPC_FENCE}:   uop = UOP_FENCE;
                {F7_CONV, F3_CONV_LD_W, OPC_CUSTOM0}: uop = UOP_CONV_LD_W;
                {F7_CONV, F3_CONV_LD_X, OPC_CUSTOM0}: uop = UOP_CONV_LD_X;
                {F7_BASE, F3_CONV_CLR,  OPC_CUSTOM0}: uop = UOP_CONV_CLR;
                {F7_BASE, F3_CONV_RUN,  OPC_CUSTOM0}: uop = UOP_CONV_RUN;
                default: illegal = 1'b1; // uop stays NOP
            endcase
        end
    end

    // operand routing follows the opcode once the word is known to be legal
    always_comb begin
        imm_fmt   = IMM_NONE;
        use_pc_a  = 1'b0;
        use_imm_b = 1'b0;
        rd_wr     = 1'b0;
        if (!illegal) begin
            case (opcode)
                OPC_LOAD, OPC_JALR: begin
                    imm_fmt   = IMM_I;
                    use_imm_b = 1'b1;
                    rd_wr     = 1'b1;
                end
                OPC_OPIMM: begin
                    // funct3 001 and 101 are the shifts
                    imm_fmt   = (instr_i[13:12] == 2'b01) ? IMM_SHAMT : IMM_I;
                    use_imm_b = 1'b1;
                    rd_wr     = 1'b1;
                end
                OPC_STORE: begin
                    imm_fmt   = IMM_S;
                    use_imm_b = 1'b1;
                end
                OPC_LUI, OPC_AUIPC: begin
                    imm_fmt   = IMM_U;
                    use_pc_a  = (opcode == OPC_AUIPC);
                    use_imm_b = 1'b1;
                    rd_wr     = 1'b1;
                end
                OPC_BRANCH: imm_fmt = IMM_B; // op_b stays rs2 for the compare
                OPC_JAL: begin
                    imm_fmt  = IMM_J;
                    use_pc_a = 1'b1;
                    rd_wr    = 1'b1;
                end
                OPC_OP:      rd_wr = 1'b1;
                OPC_CUSTOM0: rd_wr = (uop == UOP_CONV_RUN); // run returns a status word in rd
                default: ; // fence and system write nothing
            endcase
        end
    end

    always_comb begin
        case (imm_fmt)
            IMM_I:     imm = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_S:     imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:     imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
            IMM_J:     imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
            IMM_U:     imm = {instr_i[31:12], 12'b0};
            IMM_SHAMT: imm = {27'b0, instr_i[24:20]}; // shamt, no sign
            default:   imm = '0;
        endcase
    end

    assign dec_o.uop       = uop;
    assign dec_o.imm_fmt   = imm_fmt;
    assign dec_o.imm       = imm;
    assign dec_o.use_pc_a  = use_pc_a;
    assign dec_o.use_imm_b = use_imm_b;
    assign dec_o.rd        = instr_i[11:7];
    assign dec_o.rd_wr     = rd_wr;
    assign dec_o.acc_en    = (uop == UOP_CONV_LD_W) || (uop == UOP_CONV_LD_X) ? instr_i[31] : 1'b0;
    assign dec_o.illegal   = illegal;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// integer register file of the decode stage, two combinational reads and the write-back port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,
    input  wire logic [decode_pkg::REG_ADDR_W-1:0] rs1_i,
    input  wire logic [decode_pkg::REG_ADDR_W-1:0] rs2_i,
    output logic      [decode_pkg::XLEN-1:0]       rs1_data_o,
    output logic      [decode_pkg::XLEN-1:0]       rs2_data_o,
    input  decode_pkg::wb_pkt_t                    wb_i
);
    import decode_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // write lands on the edge, so a same-cycle read still sees the old value
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wr_en && (wb_i.rd != '0)) begin // x0 is never written
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: hw/operand_stage.sv
// forwarding, operand select, branch compare and the execute pipeline register of the decode stage
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  decode_pkg::dec_info_t            dec_i,
    input  wire logic                        valid_i,
    input  wire logic [decode_pkg::XLEN-1:0] pc_i,
    input  wire logic [decode_pkg::XLEN-1:0] pc_next_i,
    input  wire logic [decode_pkg::XLEN-1:0] rs1_data_i,
    input  wire logic [decode_pkg::XLEN-1:0] rs2_data_i,
    input  wire logic                        stall_i,
    input  decode_pkg::fwd_sel_e             fwd_a_i,
    input  decode_pkg::fwd_sel_e             fwd_b_i,
    input  wire logic [decode_pkg::XLEN-1:0] ex_fwd_data_i,
    input  wire logic [decode_pkg::XLEN-1:0] wb_fwd_data_i,
    output decode_pkg::ex_pkt_t              ex_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            lt;
    logic            ltu;
    logic            eq;
    ex_pkt_t         ex_next;

    // same selection for both sources
    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] rf_data,
        input logic [XLEN-1:0] ex_data,
        input logic [XLEN-1:0] wb_data
    );
        logic [XLEN-1:0] res;
        case (sel)
            FWD_EX:  res = ex_data;
            FWD_WB:  res = wb_data;
            default: res = rf_data; // FWD_NONE and the unused code
        endcase
        return res;
    endfunction

    assign src_a = fwd_mux(fwd_a_i, rs1_data_i, ex_fwd_data_i, wb_fwd_data_i);
    assign src_b = fwd_mux(fwd_b_i, rs2_data_i, ex_fwd_data_i, wb_fwd_data_i);

    // the immediate always wins over a forwarded rs2
    assign op_a = dec_i.use_pc_a  ? pc_i      : src_a;
    assign op_b = dec_i.use_imm_b ? dec_i.imm : src_b;

    // branch relations use the sources, never the selected operands
    assign lt  = $signed(src_a) < $signed(src_b);
    assign ltu = src_a < src_b;
    assign eq  = src_a == src_b;

    always_comb begin
        ex_next         = EX_BUBBLE;
        ex_next.valid   = 1'b1;
        ex_next.uop     = dec_i.uop;
        ex_next.rd      = dec_i.rd;
        ex_next.rd_wr   = dec_i.rd_wr;
        ex_next.acc_en  = dec_i.acc_en;
        ex_next.op_a    = op_a;
        ex_next.op_b    = op_b;
        ex_next.imm     = dec_i.imm;
        ex_next.pc_next = pc_next_i;
        ex_next.cmp     = {lt, ltu, eq};
        ex_next.illegal = dec_i.illegal;
    end

    // a stalled or empty slot turns into a bubble, fetch replays the stalled word
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o <= EX_BUBBLE;
        end else if (stall_i || !valid_i) begin
            ex_o <= EX_BUBBLE;
        end else begin
            ex_o <= ex_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
// top of the decode and register read stage, fetch packet in and execute packet out one cycle later
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  decode_pkg::fetch_pkt_t           fetch_i,
    input  decode_pkg::wb_pkt_t              wb_i,
    input  wire logic                        stall_i,        // from the hazard unit
    input  decode_pkg::fwd_sel_e             fwd_a_i,
    input  decode_pkg::fwd_sel_e             fwd_b_i,
    input  wire logic [decode_pkg::XLEN-1:0] ex_fwd_data_i,
    input  wire logic [decode_pkg::XLEN-1:0] wb_fwd_data_i,
    output decode_pkg::ex_pkt_t              ex_o
);
    import decode_pkg::*;

    dec_info_t       dec_info;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    instr_decoder u_instr_decoder (
        .instr_i (fetch_i.instr),
        .dec_o   (dec_info)
    );

    // register addresses come straight from the raw word, decode runs in parallel
    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (fetch_i.instr[19:15]),
        .rs2_i      (fetch_i.instr[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    operand_stage u_operand_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dec_i         (dec_info),
        .valid_i       (fetch_i.valid),
        .pc_i          (fetch_i.pc),
        .pc_next_i     (fetch_i.pc_next),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .stall_i       (stall_i),
        .fwd_a_i       (fwd_a_i),
        .fwd_b_i       (fwd_b_i),
        .ex_fwd_data_i (ex_fwd_data_i),
        .wb_fwd_data_i (wb_fwd_data_i),
        .ex_o          (ex_o)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
// testbench clock and reset source, 40 ns clock with reset held low over the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period, rising edges at 20, 60, 100
    end

    // let go on the falling edge after the third rising edge
    initial begin
        rst_n_o = 1'b0;
        #120 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/decode_stage_chk.sv
// assertion checker bound into decode_stage, watches reset, stall and illegal behaviour of ex_o
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk (
    input wire logic           clk_i,
    input wire logic           rst_n_i,
    input wire logic           stall_i,
    input decode_pkg::ex_pkt_t ex_i
);
    import decode_pkg::*;

    int unsigned fail_cnt = 0; // number of assertion failures so far

    // nothing leaves the stage while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !ex_i.valid)
        else begin
            $error("ex_o.valid high during reset");
            fail_cnt++;
        end

    stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> (ex_i == EX_BUBBLE))
        else begin
            $error("stall edge was not followed by a bubble");
            fail_cnt++;
        end

    illegal_is_nop: assert property (@(posedge clk_i) ex_i.illegal |-> (ex_i.uop == UOP_NOP))
        else begin
            $error("illegal packet carries a micro-op");
            fail_cnt++;
        end

endmodule

bind decode_stage decode_stage_chk u_decode_stage_chk (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .ex_i    (ex_o)
);

`default_nettype wire

// File: sim/tb_decode_stage.sv
// testbench for the decode stage, drives instruction streams and checks ex_o against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
    import decode_pkg::*;

    localparam int  N_OPC     = 12;
    localparam int  N_FWD     = 200;
    localparam int  N_BR      = 64;
    localparam int  N_RAND    = 200;
    localparam int  N_VECTORS = 2 * NUM_REGS + N_OPC * 32 + 2 + N_FWD + N_BR + N_RAND + 4;
    localparam time TIMEOUT   = (N_VECTORS + 20) * 40; // one vector per 40 ns cycle plus slack

    logic            clk;
    logic            rst_n;
    fetch_pkt_t      fetch;
    wb_pkt_t         wb;
    logic            stall;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [XLEN-1:0] ex_fwd_data;
    logic [XLEN-1:0] wb_fwd_data;
    ex_pkt_t         ex;

    int              seed = 32'hfbcb725a;
    logic [XLEN-1:0] shadow [NUM_REGS]; // mirror of the register file
    ex_pkt_t         exp_q [$];
    int              issued = 0;
    int              checked = 0;
    int              fail_count = 0;

    // uop per funct3, NOP marks a hole in the encoding
    uop_e op_tab [8]     = '{UOP_ADD, UOP_SLL, UOP_SLT, UOP_SLTU, UOP_XOR, UOP_SRL, UOP_OR, UOP_AND};
    uop_e opimm_tab [8]  = '{UOP_ADDI, UOP_SLLI, UOP_SLTI, UOP_SLTIU,
                             UOP_XORI, UOP_SRLI, UOP_ORI, UOP_ANDI};
    uop_e load_tab [8]   = '{UOP_LB, UOP_LH, UOP_LW, UOP_NOP, UOP_LBU, UOP_LHU, UOP_NOP, UOP_NOP};
    uop_e store_tab [8]  = '{UOP_SB, UOP_SH, UOP_SW, UOP_NOP, UOP_NOP, UOP_NOP, UOP_NOP, UOP_NOP};
    uop_e branch_tab [8] = '{UOP_BEQ, UOP_BNE, UOP_NOP, UOP_NOP,
                             UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU};
    logic [6:0] opc_tab [N_OPC] = '{OPC_LOAD, OPC_OPIMM, OPC_AUIPC, OPC_STORE, OPC_OP, OPC_LUI,
                                    OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_SYSTEM, OPC_FENCE,
                                    OPC_CUSTOM0};
    logic [6:0] f7_tab [4] = '{7'h00, 7'h20, 7'h01, 7'h40}; // 7'h40 is a conv load with acc set

    // compare pairs: equal, sign boundary, signed and unsigned order disagreeing
    logic [XLEN-1:0] edge_a [8] = '{32'h5, 32'h7fffffff, 32'h80000000, 32'hffffffff,
                                    32'h1, 32'h0, 32'h80000000, 32'h0};
    logic [XLEN-1:0] edge_b [8] = '{32'h5, 32'h80000000, 32'h7fffffff, 32'h1,
                                    32'hffffffff, 32'hffffffff, 32'h80000000, 32'h0};

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_stage dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .fetch_i       (fetch),
        .wb_i          (wb),
        .stall_i       (stall),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_fwd_data_i (wb_fwd_data),
        .ex_o          (ex)
    );

    function automatic logic [XLEN-1:0] pick_src(input fwd_sel_e sel, input logic [4:0] rs);
        case (sel)
            FWD_EX:  return ex_fwd_data;
            FWD_WB:  return wb_fwd_data;
            default: return (rs == 5'd0) ? '0 : shadow[rs]; // x0 reads zero
        endcase
    endfunction

    // expected execute packet for the inputs driven in this cycle
    function automatic ex_pkt_t expect_pkt(input fetch_pkt_t f, input logic stl);
        ex_pkt_t         e;
        logic [31:0]     w;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        logic            pc_a;
        logic            imm_b;
        logic            rd_wr;
        logic            acc;
        uop_e            uop;
        e = '0; // bubble
        if (stl || !f.valid) begin
            return e;
        end
        w     = f.instr;
        f3    = w[14:12];
        f7    = w[31:25];
        uop   = UOP_NOP;
        imm   = '0;
        pc_a  = 1'b0;
        imm_b = 1'b0;
        rd_wr = 1'b0;
        acc   = 1'b0;
        case (w[6:0])
            OPC_OP: begin
                rd_wr = 1'b1;
                if (f7 == 7'h00) begin
                    uop = op_tab[f3];
                end else if (f7 == 7'h01) begin
                    uop = uop_e'(UOP_MUL + f3); // M ops follow funct3 order
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    uop = UOP_SUB;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    uop = UOP_SRA;
                end
            end
            OPC_OPIMM: begin
                uop   = opimm_tab[f3];
                imm   = (f3[1:0] == 2'b01) ? {27'd0, w[24:20]} : {{20{w[31]}}, w[31:20]};
                imm_b = 1'b1;
                rd_wr = 1'b1;
                if (f3 == 3'd5 && f7 == 7'h20) begin
                    uop = UOP_SRAI;
                end else if (f3[1:0] == 2'b01 && f7 != 7'h00) begin
                    uop = UOP_NOP; // bad shift funct7
                end
            end
            OPC_LOAD, OPC_JALR: begin
                uop   = (w[6:0] == OPC_LOAD) ? load_tab[f3] : ((f3 == 3'd0) ? UOP_JALR : UOP_NOP);
                imm   = {{20{w[31]}}, w[31:20]};
                imm_b = 1'b1;
                rd_wr = 1'b1;
            end
            OPC_STORE: begin
                uop   = store_tab[f3];
                imm   = {{20{w[31]}}, w[31:25], w[11:7]};
                imm_b = 1'b1;
            end
            OPC_BRANCH: begin
                uop = branch_tab[f3];
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_JAL: begin
                uop   = UOP_JAL;
                imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                pc_a  = 1'b1;
                rd_wr = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                uop   = (w[6:0] == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
                imm   = {w[31:12], 12'd0};
                pc_a  = (w[6:0] == OPC_AUIPC);
                imm_b = 1'b1;
                rd_wr = 1'b1;
            end
            OPC_FENCE:  uop = (f3 == 3'd0) ? UOP_FENCE : UOP_NOP;
            OPC_SYSTEM: begin
                if (w == INSTR_ECALL) begin
                    uop = UOP_ECALL;
                end else if (w == INSTR_EBREAK) begin
                    uop = UOP_EBREAK;
                end
            end
            OPC_CUSTOM0: begin
                if (f3 <= 3'd1 && f7[5:0] == 6'd0) begin
                    uop = f3[0] ? UOP_CONV_LD_X : UOP_CONV_LD_W;
                    acc = w[31];
                end else if (f3 <= 3'd3 && f7 == 7'h00) begin
                    uop   = f3[0] ? UOP_CONV_RUN : UOP_CONV_CLR;
                    rd_wr = f3[0]; // only run returns a value
                end
            end
            default: ;
        endcase
        if (uop == UOP_NOP) begin // nothing matched, drop all routing
            imm   = '0;
            pc_a  = 1'b0;
            imm_b = 1'b0;
            rd_wr = 1'b0;
        end
        src_a     = pick_src(fwd_a, w[19:15]);
        src_b     = pick_src(fwd_b, w[24:20]);
        e.valid   = 1'b1;
        e.uop     = uop;
        e.rd      = w[11:7];
        e.rd_wr   = rd_wr;
        e.acc_en  = acc;
        e.op_a    = pc_a ? f.pc : src_a;
        e.op_b    = imm_b ? imm : src_b;
        e.imm     = imm;
        e.pc_next = f.pc_next;
        e.cmp     = {$signed(src_a) < $signed(src_b), src_a < src_b, src_a == src_b};
        e.illegal = (uop == UOP_NOP);
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            fail_count++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic scramble_side_inputs(input logic fwd_on, input logic wb_on);
        fwd_a       = fwd_on ? fwd_sel_e'($unsigned($random(seed)) % 3) : FWD_NONE;
        fwd_b       = fwd_on ? fwd_sel_e'($unsigned($random(seed)) % 3) : FWD_NONE;
        ex_fwd_data = $random(seed);
        wb_fwd_data = $random(seed);
        wb.wr_en    = wb_on && (($random(seed) & 1) != 0);
        wb.rd       = $random(seed);
        wb.data     = $random(seed);
    endtask

    // called on a falling edge, returns on the next one
    task automatic issue(input logic [XLEN-1:0] instr, input logic vld, input logic stl);
        logic [XLEN-1:0] pc;
        pc            = $random(seed) & 32'hffff_fffc;
        fetch.valid   = vld;
        fetch.instr   = instr;
        fetch.pc      = pc;
        fetch.pc_next = pc + 32'd4;
        stall         = stl;
        exp_q.push_back(expect_pkt(fetch, stl));
        issued++;
        if (wb.wr_en && wb.rd != 5'd0) begin
            shadow[wb.rd] = wb.data; // lands at the coming rising edge
        end
        @(negedge clk);
    endtask

    initial begin : compare_proc
        ex_pkt_t want;
        ex_pkt_t got;
        logic    popped;
        forever begin
            @(posedge clk);
            popped = (exp_q.size() > 0);
            if (popped) begin
                want = exp_q.pop_front();
            end else begin
                want = EX_BUBBLE; // idle before the first vector
            end
            @(negedge clk);
            got = ex;
            check_value("valid", got.valid, want.valid);
            check_value("uop", got.uop, want.uop);
            check_value("rd", got.rd, want.rd);
            check_value("rd_wr", got.rd_wr, want.rd_wr);
            check_value("acc_en", got.acc_en, want.acc_en);
            check_value("op_a", got.op_a, want.op_a);
            check_value("op_b", got.op_b, want.op_b);
            check_value("imm", got.imm, want.imm);
            check_value("pc_next", got.pc_next, want.pc_next);
            check_value("cmp", got.cmp, want.cmp);
            check_value("illegal", got.illegal, want.illegal);
            if (popped) begin
                checked++;
            end
        end
    end

    initial begin : assertion_watch
        wait (dut.u_decode_stage_chk.fail_cnt != 0);
        $display("an assertion of the bound checker failed at %0d ns", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin : stimulus
        logic [31:0] w;
        fetch       = '0;
        wb          = '0;
        stall       = 1'b0;
        fwd_a       = FWD_NONE;
        fwd_b       = FWD_NONE;
        ex_fwd_data = '0;
        wb_fwd_data = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        wait (rst_n);
        @(posedge clk);
        @(negedge clk);

        // write every register, x0 too, then read them all back through ADD
        for (int r = 0; r < NUM_REGS; r++) begin
            scramble_side_inputs(1'b0, 1'b0);
            wb.wr_en = 1'b1;
            wb.rd    = 5'(r);
            issue($random(seed), 1'b0, 1'b0);
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            scramble_side_inputs(1'b0, 1'b0);
            issue({F7_BASE, 5'(NUM_REGS - 1 - r), 5'(r), 3'b000, 5'(r), OPC_OP}, 1'b1, 1'b0);
        end

        // every opcode, funct3 and funct7 choice with the other fields random
        for (int o = 0; o < N_OPC; o++) begin
            for (int f = 0; f < 8; f++) begin
                for (int k = 0; k < 4; k++) begin
                    scramble_side_inputs(1'b1, 1'b1);
                    w        = $random(seed);
                    w[31:25] = f7_tab[k];
                    w[14:12] = 3'(f);
                    w[6:0]   = opc_tab[o];
                    issue(w, 1'b1, 1'b0);
                end
            end
        end
        issue(INSTR_ECALL, 1'b1, 1'b0);
        issue(INSTR_EBREAK, 1'b1, 1'b0);

        // forwarding on ADD and ADDI, the immediate must stay in op_b
        for (int n = 0; n < N_FWD; n++) begin
            scramble_side_inputs(1'b1, 1'b1);
            w        = $random(seed);
            w[31:25] = F7_BASE;
            w[14:12] = 3'b000;
            w[6:0]   = n[0] ? OPC_OPIMM : OPC_OP;
            issue(w, 1'b1, 1'b0);
        end

        // compare relations, edge pairs through the forward paths first
        for (int n = 0; n < N_BR; n++) begin
            scramble_side_inputs(n >= 8, 1'b1);
            if (n < 8) begin
                fwd_a       = FWD_EX;
                fwd_b       = FWD_WB;
                ex_fwd_data = edge_a[n];
                wb_fwd_data = edge_b[n];
            end
            w      = $random(seed);
            w[6:0] = OPC_BRANCH;
            issue(w, 1'b1, 1'b0);
        end

        // raw words, mostly illegal, with empty slots and stalls mixed in
        for (int n = 0; n < N_RAND; n++) begin
            scramble_side_inputs(1'b1, 1'b1);
            w = $random(seed);
            issue(w, ($random(seed) & 3) != 0, ($random(seed) & 7) == 0);
        end

        // stalled word offered again, then drain
        w = {F7_BASE, 5'd3, 5'd4, 3'b000, 5'd5, OPC_OP};
        scramble_side_inputs(1'b1, 1'b0);
        issue(w, 1'b1, 1'b1);
        issue(w, 1'b1, 1'b0);
        scramble_side_inputs(1'b0, 1'b0);
        issue(32'h0, 1'b0, 1'b0);
        issue(32'h0, 1'b0, 1'b0);
        wait (checked == issued);

        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "%0d checks failed", fail_count);
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("timeout: the expected packets were not all seen within %0d ns", TIMEOUT);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: list.f
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_stage.sv
hw/decode_stage.sv
sim/clk_gen.sv
sim/decode_stage_chk.sv
sim/tb_decode_stage.sv
